// ==== compile.f ====
+incdir+src
+incdir+tb
src/fpm_format_pkg.sv
src/fpm_regs_pkg.sv
src/fpm_axil_ctrl.sv
src/fpm_unpack_mul.sv
src/fpm_round_pack.sv
src/fpm_top.sv
tb/tb_fpm.sv

// ==== tb/fpm_model.svh ====
// Reference model of the FP multiplier that rounds the exact product by the mode rules
`ifndef FPM_MODEL_SVH
`define FPM_MODEL_SVH

// Directed mode pointing the same way as the sign
function automatic bit mode_toward_sign(input logic [2:0] mode, input logic sign);
  return (mode == 3'd2 && !sign) || (mode == 3'd3 && sign);
endfunction

// Expected {flags, z} for one multiply
function automatic logic [37:0] ref_multiply(input logic [31:0] a, input logic [31:0] b,
                                             input logic [2:0] mode);
  logic            sign;
  int              ea;
  int              eb;
  int              e;
  int              shift;
  longint unsigned prod;
  longint unsigned keep;
  longint unsigned rem;
  longint unsigned half;
  bit              up;
  logic [31:0]     z;
  fp_status_t      f;
  ea   = a[30:23];
  eb   = b[30:23];
  sign = a[31] ^ b[31];
  f    = '0;
  if ((ea == `FPM_EXP_MAX || eb == `FPM_EXP_MAX) && (ea == 0 || eb == 0)) begin
    f.invalid  = 1'b1;
    f.infinity = 1'b1;
    return {f, 32'h7F80_0000};
  end
  if (ea == `FPM_EXP_MAX || eb == `FPM_EXP_MAX) begin
    f.infinity = 1'b1;
    return {f, sign, 8'hFF, 23'd0};
  end
  if (ea == 0 || eb == 0) begin
    f.zero = 1'b1;
    return {f, sign, 31'd0};
  end
  prod  = longint'({1'b1, a[22:0]}) * longint'({1'b1, b[22:0]});
  e     = ea + eb - `FPM_BIAS;
  // Exact product lies in [1,4), keep its top 24 bits
  shift = (prod >= (64'd1 << 47)) ? 24 : 23;
  e     = e + shift - 23;
  keep  = prod >> shift;
  rem   = prod - (keep << shift);
  half  = 64'd1 << (shift - 1);
  case (mode)
    3'd0:       up = (rem > half) || (rem == half && keep % 2 == 1);
    3'd2, 3'd3: up = mode_toward_sign(mode, sign) && rem != 0;
    3'd4:       up = (rem >= half);
    3'd5:       up = (rem != 0);
    default:    up = 1'b0;
  endcase
  keep = keep + up;
  if (keep == (64'd1 << 24)) begin
    keep = keep >> 1;
    e    = e + 1;
  end
  if (e >= `FPM_EXP_MAX) begin
    f.huge    = 1'b1;
    f.inexact = 1'b1;
    if (mode == 3'd0 || mode == 3'd4 || mode == 3'd5 || mode_toward_sign(mode, sign)) begin
      f.infinity = 1'b1;
      z = {sign, 8'hFF, 23'd0};
    end else begin
      z = {sign, 8'hFE, 23'h7F_FFFF};
    end
  end else if (e <= 0) begin
    f.tiny    = 1'b1;
    f.inexact = 1'b1;
    if (mode == 3'd5 || mode_toward_sign(mode, sign)) begin
      z = {sign, 8'h01, 23'd0};
    end else begin
      z = {sign, 31'd0};
      f.zero = 1'b1;
    end
  end else begin
    f.inexact = (rem != 0);
    z = {sign, e[7:0], keep[22:0]};
  end
  return {f, z};
endfunction

`endif

// ==== tb/tb_fpm.sv ====
// Testbench for the AXI4-Lite FP multiplier with random operands checked against a reference model
`include "fpm_defs.svh"

module tb_fpm
  import fpm_format_pkg::*, fpm_regs_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_NORMAL  = 300;
  localparam int N_OVF     = 60;
  localparam int N_TINY    = 60;
  localparam int N_SPECIAL = 24;
  localparam int N_BUS     = 20;
  // Each multiply or bus step gets a budget of 40 cycles
  localparam int N_TXN       = N_NORMAL + N_OVF + N_TINY + N_SPECIAL + N_BUS;
  localparam int CYCLE_LIMIT = 40 * N_TXN;

  logic        clk;
  logic        arst_n;
  logic [31:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [31:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  integer seed;
  int     cycles;
  int     tests;
  int     checks;
  int     errors;
  int     chk_mark;
  int     err_mark;
  string  ctx;

  `include "fpm_model.svh"

  fpm_top fpm_top_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: no finish within %0d clock cycles", CYCLE_LIMIT);
      $display("TEST FAIL");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // Bus tasks called right after a rising edge
  // ----------------------------------------------------------
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] resp);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= strb;
    wvalid  <= 1'b1;
    do @(posedge clk); while (!(awready && wready));
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    bready  <= 1'b1;
    do @(posedge clk); while (!bvalid);
    resp = bresp;
    bready <= 1'b0;
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    araddr  <= addr;
    arvalid <= 1'b1;
    do @(posedge clk); while (!arready);
    arvalid <= 1'b0;
    rready  <= 1'b1;
    do @(posedge clk); while (!rvalid);
    data = rdata;
    resp = rresp;
    rready <= 1'b0;
  endtask

  // Polls STATUS until the done bit is set
  task automatic wait_done(output logic [31:0] status);
    logic [1:0] resp;
    do bus_read(`FPM_REG_STATUS, status, resp); while (!status[8]);
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    checks++;
    assert (got === expected) else begin
      $display("MISMATCH %s: got %h, expected %h (%s)", name, got, expected, ctx);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("%-16s %0d checks, %0d errors", name, checks - chk_mark, errors - err_mark);
    chk_mark = checks;
    err_mark = errors;
  endtask

  // Float with random sign and fraction and a biased exponent in lo .. lo+span-1
  function automatic logic [31:0] rand_float(input int lo, input int span);
    logic [31:0] r;
    logic [7:0]  e;
    r = $random(seed);
    e = 8'(lo + ($unsigned($random(seed)) % span));
    return {r[31], e, r[22:0]};
  endfunction

  task automatic run_mul(input logic [31:0] a, input logic [31:0] b, input logic [2:0] mode);
    logic [37:0] expected;
    logic [31:0] status;
    logic [31:0] result;
    logic [1:0]  resp;
    expected = ref_multiply(a, b, mode);
    ctx = $sformatf("a=%h b=%h rnd=%0d", a, b, mode);
    bus_write(`FPM_REG_OPA, a, 4'hF, resp);
    bus_write(`FPM_REG_RND, {29'd0, mode}, 4'h1, resp);
    bus_write(`FPM_REG_OPB, b, 4'hF, resp);
    wait_done(status);
    bus_read(`FPM_REG_RESULT, result, resp);
    check_word("z", result, expected[31:0]);
    check_word("flags", {26'd0, status[5:0]}, {26'd0, expected[37:32]});
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] b2;
    logic [31:0] r;
    logic [31:0] data;
    logic [31:0] zero_w;
    logic [31:0] inf_w;
    logic [37:0] expected;
    logic [2:0]  m;
    logic [1:0]  resp;
    reg_idx_t    bad_idx;
    seed    = 25548;
    clk     = 1'b0;
    arst_n  = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);

    // Handshake outputs idle after reset
    ctx = "reset";
    check_word("awready", awready, 1'b1);
    check_word("wready", wready, 1'b1);
    check_word("arready", arready, 1'b1);
    check_word("bvalid", bvalid, 1'b0);
    check_word("rvalid", rvalid, 1'b0);
    finish_test("reset");

    for (int i = 0; i < N_NORMAL; i++) begin
      run_mul(rand_float(64, 127), rand_float(64, 127), 3'(i % 8));
    end
    finish_test("normal");

    for (int i = 0; i < N_OVF; i++) begin
      run_mul(rand_float(190, 64), rand_float(190, 64), 3'(i % 8));
    end
    finish_test("overflow");

    // Exponent sums straddle zero so a few land just above tiny
    for (int i = 0; i < N_TINY; i++) begin
      run_mul(rand_float(1, 64), rand_float(1, 64), 3'(i % 8));
    end
    finish_test("tiny");

    for (int i = 0; i < N_SPECIAL; i++) begin
      r      = $random(seed);
      zero_w = {r[31], 8'h00, r[22:0]};
      inf_w  = {r[30], 8'hFF, r[22:0]};
      a      = (i % 3 == 0) ? zero_w : inf_w;
      b      = (i % 3 == 2) ? zero_w : rand_float(1, 254);
      if (i % 2 == 1) begin
        run_mul(b, a, 3'(i % 8));
      end else begin
        run_mul(a, b, 3'(i % 8));
      end
    end
    finish_test("special");

    // ----------------------------------------------------------
    // Register access, error responses and back-to-back launches
    // ----------------------------------------------------------
    a   = rand_float(64, 127);
    b   = rand_float(64, 127);
    b2  = rand_float(64, 127);
    r   = $random(seed);
    m   = r[2:0];
    ctx = $sformatf("bus a=%h b=%h rnd=%0d", a, b, m);
    bus_write(`FPM_REG_OPA, a, 4'hF, resp);
    check_word("bresp", resp, RESP_OKAY);
    bus_write(`FPM_REG_RND, {29'd0, m}, 4'h1, resp);
    bus_write(`FPM_REG_OPB, b, 4'hF, resp);
    check_word("bresp", resp, RESP_OKAY);
    bus_read(`FPM_REG_STATUS, data, resp);
    check_word("done", data[8], 1'b0);
    wait_done(data);
    bus_read(`FPM_REG_STATUS, data, resp);
    check_word("done", data[8], 1'b1);
    bus_read(`FPM_REG_OPA, data, resp);
    check_word("opa", data, a);
    check_word("rresp", resp, RESP_OKAY);
    bus_read(`FPM_REG_OPB, data, resp);
    check_word("opb", data, b);
    bus_read(`FPM_REG_RND, data, resp);
    check_word("rnd", data, {29'd0, m});

    expected = ref_multiply(a, b, m);
    bus_write(`FPM_REG_RESULT, 32'h1234_5678, 4'hF, resp);
    check_word("bresp", resp, RESP_SLVERR);
    bus_read(`FPM_REG_RESULT, data, resp);
    check_word("z", data, expected[31:0]);
    bad_idx = 3'd5;
    bus_write({27'd0, bad_idx, 2'b00}, 32'hFFFF_FFFF, 4'hF, resp);
    check_word("bresp", resp, RESP_SLVERR);
    bus_read({27'd0, bad_idx + 3'd1, 2'b00}, data, resp);
    check_word("rresp", resp, RESP_SLVERR);
    check_word("rdata", data, 32'd0);

    // Second OPB write lands two cycles after the first and the first result is read in between
    expected = ref_multiply(a, b2, m);
    bus_write(`FPM_REG_OPB, b2, 4'hF, resp);
    bus_write(`FPM_REG_OPB, b, 4'hF, resp);
    bus_read(`FPM_REG_RESULT, data, resp);
    check_word("z", data, expected[31:0]);
    wait_done(data);
    expected = ref_multiply(a, b, m);
    bus_read(`FPM_REG_RESULT, data, resp);
    check_word("z", data, expected[31:0]);
    finish_test("bus");

    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== src/fpm_top.sv ====
// FP multiplier top joining the AXI4-Lite control block to the two datapath stages
module fpm_top
  import fpm_format_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic [31:0] awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [31:0] araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready
);

  logic       launch;
  fp_word_t   op_a;
  fp_word_t   op_b;
  rnd_mode_t  rnd;
  logic       s1_valid;
  logic       s1_sign;
  exp_sum_t   s1_exp;
  prod_t      s1_prod;
  logic       s1_zero_in;
  logic       s1_inf_in;
  rnd_mode_t  s1_rnd;
  logic       s2_valid;
  fp_word_t   z;
  fp_status_t flags;

  fpm_axil_ctrl ctrl_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .awaddr   (awaddr),
    .awvalid  (awvalid),
    .awready  (awready),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .wvalid   (wvalid),
    .wready   (wready),
    .bresp    (bresp),
    .bvalid   (bvalid),
    .bready   (bready),
    .araddr   (araddr),
    .arvalid  (arvalid),
    .arready  (arready),
    .rdata    (rdata),
    .rresp    (rresp),
    .rvalid   (rvalid),
    .rready   (rready),
    .s2_valid (s2_valid),
    .z        (z),
    .flags    (flags),
    .launch   (launch),
    .op_a     (op_a),
    .op_b     (op_b),
    .rnd      (rnd)
  );

  // Stage 1, unpack and multiply
  fpm_unpack_mul unpack_mul_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .launch     (launch),
    .op_a       (op_a),
    .op_b       (op_b),
    .rnd        (rnd),
    .s1_valid   (s1_valid),
    .s1_sign    (s1_sign),
    .s1_exp     (s1_exp),
    .s1_prod    (s1_prod),
    .s1_zero_in (s1_zero_in),
    .s1_inf_in  (s1_inf_in),
    .s1_rnd     (s1_rnd)
  );

  // Stage 2, round and pack
  fpm_round_pack round_pack_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .s1_valid   (s1_valid),
    .s1_sign    (s1_sign),
    .s1_exp     (s1_exp),
    .s1_prod    (s1_prod),
    .s1_zero_in (s1_zero_in),
    .s1_inf_in  (s1_inf_in),
    .s1_rnd     (s1_rnd),
    .s2_valid   (s2_valid),
    .z          (z),
    .flags      (flags)
  );

endmodule

// ==== src/fpm_round_pack.sv ====
// Second multiplier stage that normalizes, rounds, resolves overflow and tiny results and packs the word
`include "fpm_defs.svh"

module fpm_round_pack
  import fpm_format_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       s1_valid,
  input  logic       s1_sign,
  input  exp_sum_t   s1_exp,
  input  prod_t      s1_prod,
  input  logic       s1_zero_in,
  input  logic       s1_inf_in,
  input  rnd_mode_t  s1_rnd,
  output logic       s2_valid,
  output fp_word_t   z,
  output fp_status_t flags
);

  localparam int MW = `FPM_SIG_WIDTH + 1;
  localparam int PW = 2 * MW;
  localparam int EW = `FPM_EXP_WIDTH;

  prod_t      norm;
  logic [MW-1:0] mant;
  logic       guard;
  logic       round_bit;
  logic       sticky;
  logic       inexact;
  logic       toward_sign;
  logic       inc;
  logic [MW:0] rounded;
  exp_sum_t   exp_fin;
  logic       huge;
  logic       tiny;
  logic       huge_to_inf;
  logic       tiny_to_min;
  fp_word_t   z_d;
  fp_status_t flags_d;

  // ----------------------------------------------------------
  // Normalize and round
  // ----------------------------------------------------------
  // Product lies in [1,4), one left shift when below 2
  assign norm      = s1_prod[PW-1] ? s1_prod : {s1_prod[PW-2:0], 1'b0};
  assign mant      = norm[PW-1 -: MW];
  assign guard     = norm[PW-MW-1];
  assign round_bit = norm[PW-MW-2];
  assign sticky    = |norm[PW-MW-3:0];
  assign inexact   = guard | round_bit | sticky;

  // Directed mode that rounds away from zero for this sign
  assign toward_sign = (s1_rnd == RND_TO_POS && !s1_sign) ||
                       (s1_rnd == RND_TO_NEG && s1_sign);

  always_comb begin
    case (s1_rnd)
      RND_NEAREST_EVEN:       inc = guard & (round_bit | sticky | mant[0]);
      RND_NEAREST_UP:         inc = guard;
      RND_AWAY:               inc = inexact;
      RND_TO_POS, RND_TO_NEG: inc = toward_sign & inexact;
      default:                inc = 1'b0;
    endcase
  end

  assign rounded = {1'b0, mant} + (MW+1)'(inc);

  // Carry out leaves 1.000..0, fraction bits are already zero
  assign exp_fin = s1_exp + exp_sum_t'(s1_prod[PW-1]) + exp_sum_t'(rounded[MW]);

  assign huge = (exp_fin >= `FPM_EXP_MAX);
  assign tiny = (exp_fin <= 0);

  assign huge_to_inf = (s1_rnd == RND_NEAREST_EVEN) || (s1_rnd == RND_NEAREST_UP) ||
                       (s1_rnd == RND_AWAY) || toward_sign;
  assign tiny_to_min = (s1_rnd == RND_AWAY) || toward_sign;

  // ----------------------------------------------------------
  // Result selection and flags
  // ----------------------------------------------------------
  always_comb begin
    z_d.sign = s1_sign;
    z_d.exp  = exp_fin[EW-1:0];
    z_d.frac = rounded[MW-2:0];
    flags_d  = '0;

    if (s1_inf_in) begin
      // Infinity times zero lands here too, sign already plus
      z_d.exp          = EW'(`FPM_EXP_MAX);
      z_d.frac         = '0;
      flags_d.infinity = 1'b1;
      flags_d.invalid  = s1_zero_in;
    end else if (s1_zero_in) begin
      z_d.exp      = '0;
      z_d.frac     = '0;
      flags_d.zero = 1'b1;
    end else if (huge) begin
      flags_d.huge    = 1'b1;
      flags_d.inexact = 1'b1;
      if (huge_to_inf) begin
        z_d.exp          = EW'(`FPM_EXP_MAX);
        z_d.frac         = '0;
        flags_d.infinity = 1'b1;
      end else begin
        // Largest finite number
        z_d.exp  = EW'(`FPM_EXP_MAX - 1);
        z_d.frac = '1;
      end
    end else if (tiny) begin
      flags_d.tiny    = 1'b1;
      flags_d.inexact = 1'b1;
      z_d.frac        = '0;
      if (tiny_to_min) begin
        z_d.exp = EW'(1);
      end else begin
        z_d.exp      = '0;
        flags_d.zero = 1'b1;
      end
    end else begin
      flags_d.inexact = inexact;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      z     <= z_d;
      flags <= flags_d;
    end
  end

endmodule

// ==== src/fpm_unpack_mul.sv ====
// First multiplier stage that classifies the operands, sums exponents and multiplies significands
`include "fpm_defs.svh"

module fpm_unpack_mul
  import fpm_format_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  logic      launch,
  input  fp_word_t  op_a,
  input  fp_word_t  op_b,
  input  rnd_mode_t rnd,
  output logic      s1_valid,
  output logic      s1_sign,
  output exp_sum_t  s1_exp,
  output prod_t     s1_prod,
  output logic      s1_zero_in,
  output logic      s1_inf_in,
  output rnd_mode_t s1_rnd
);

  localparam int MW = `FPM_SIG_WIDTH + 1;
  localparam logic [`FPM_EXP_WIDTH-1:0] EXP_ALL_ONES = `FPM_EXP_WIDTH'(`FPM_EXP_MAX);

  logic          zero_a;
  logic          zero_b;
  logic          inf_a;
  logic          inf_b;
  logic          zero_in;
  logic          inf_in;
  logic          sign_d;
  logic [MW-1:0] mant_a;
  logic [MW-1:0] mant_b;
  exp_sum_t      exp_d;
  prod_t         prod_d;

  // No denormals or NaNs, exponent field alone decides
  assign zero_a  = (op_a.exp == '0);
  assign zero_b  = (op_b.exp == '0);
  assign inf_a   = (op_a.exp == EXP_ALL_ONES);
  assign inf_b   = (op_b.exp == EXP_ALL_ONES);
  assign zero_in = zero_a || zero_b;
  assign inf_in  = inf_a || inf_b;

  // Invalid product is always plus infinity
  assign sign_d = (op_a.sign ^ op_b.sign) & ~(zero_in & inf_in);

  assign exp_d = exp_sum_t'(op_a.exp) + exp_sum_t'(op_b.exp) - exp_sum_t'(`FPM_BIAS);

  // Hidden one restored on both sides
  assign mant_a = {1'b1, op_a.frac};
  assign mant_b = {1'b1, op_b.frac};
  assign prod_d = mant_a * mant_b;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= launch;
    end
  end

  always_ff @(posedge clk) begin
    if (launch) begin
      s1_sign    <= sign_d;
      s1_exp     <= exp_d;
      s1_prod    <= prod_d;
      s1_zero_in <= zero_in;
      s1_inf_in  <= inf_in;
      s1_rnd     <= rnd;
    end
  end

endmodule

// ==== src/fpm_axil_ctrl.sv ====
// AXI4-Lite slave holding the operand and mode registers, launching multiplies and capturing results
`include "fpm_defs.svh"

module fpm_axil_ctrl
  import fpm_format_pkg::*, fpm_regs_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic [31:0] awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [31:0] araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready,
  input  logic        s2_valid,
  input  fp_word_t    z,
  input  fp_status_t  flags,
  output logic        launch,
  output fp_word_t    op_a,
  output fp_word_t    op_b,
  output rnd_mode_t   rnd
);

  localparam reg_idx_t IDX_OPA    = reg_idx_t'(`FPM_REG_OPA >> 2);
  localparam reg_idx_t IDX_OPB    = reg_idx_t'(`FPM_REG_OPB >> 2);
  localparam reg_idx_t IDX_RND    = reg_idx_t'(`FPM_REG_RND >> 2);
  localparam reg_idx_t IDX_RESULT = reg_idx_t'(`FPM_REG_RESULT >> 2);
  localparam reg_idx_t IDX_STATUS = reg_idx_t'(`FPM_REG_STATUS >> 2);

  // Counts products in flight, launch cycle included
  localparam int CNT_W = $clog2(`FPM_LATENCY + 2);

  reg_idx_t         wr_idx;
  reg_idx_t         rd_idx;
  logic             wr_fire;
  logic             wr_ok;
  logic             op_start;
  logic             rd_fire;
  logic             rd_ok;
  logic [31:0]      rd_word;
  logic [CNT_W-1:0] inflight;
  logic             done;
  fp_word_t         result;
  fp_status_t       status;

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strb);
    logic [31:0] res;
    res = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return res;
  endfunction

  // ----------------------------------------------------------
  // Write channel
  // ----------------------------------------------------------
  assign awready  = !bvalid;
  assign wready   = !bvalid;
  assign wr_fire  = awvalid && wvalid && !bvalid;
  assign wr_idx   = reg_idx_t'(awaddr[4:2]);
  // RESULT and STATUS are read only
  assign wr_ok    = (awaddr[31:5] == '0) &&
                    (wr_idx == IDX_OPA || wr_idx == IDX_OPB || wr_idx == IDX_RND);
  assign op_start = wr_fire && wr_ok && (wr_idx == IDX_OPB);

  // ----------------------------------------------------------
  // Read channel
  // ----------------------------------------------------------
  assign arready = !rvalid;
  assign rd_fire = arvalid && !rvalid;
  assign rd_idx  = reg_idx_t'(araddr[4:2]);
  assign rd_ok   = (araddr[31:5] == '0) && (rd_idx <= IDX_STATUS);

  always_comb begin
    case (rd_idx)
      IDX_OPA:    rd_word = op_a;
      IDX_OPB:    rd_word = op_b;
      IDX_RND:    rd_word = {29'd0, rnd};
      IDX_RESULT: rd_word = result;
      IDX_STATUS: rd_word = {23'd0, done, 2'd0, status};
      default:    rd_word = '0;
    endcase
  end

  // Handshake, launch and done tracking
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bvalid   <= 1'b0;
      rvalid   <= 1'b0;
      launch   <= 1'b0;
      done     <= 1'b0;
      inflight <= '0;
      op_a     <= '0;
      op_b     <= '0;
      rnd      <= RND_NEAREST_EVEN;
    end else begin
      launch <= op_start;

      if (wr_fire) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end

      if (rd_fire) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end

      if (wr_fire && wr_ok) begin
        case (wr_idx)
          IDX_OPA: op_a <= fp_word_t'(merge_bytes(op_a, wdata, wstrb));
          IDX_OPB: op_b <= fp_word_t'(merge_bytes(op_b, wdata, wstrb));
          default: begin
            if (wstrb[0]) begin
              rnd <= rnd_mode_t'(wdata[2:0]);
            end
          end
        endcase
      end

      case ({op_start, s2_valid})
        2'b10:   inflight <= inflight + 1'b1;
        2'b01:   inflight <= inflight - 1'b1;
        default: inflight <= inflight;
      endcase

      // Done only once the last product in flight has returned
      if (op_start) begin
        done <= 1'b0;
      end else if (s2_valid && inflight == CNT_W'(1)) begin
        done <= 1'b1;
      end
    end
  end

  // Responses and captured results
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_fire) begin
      rdata <= rd_ok ? rd_word : '0;
      rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
    end
    if (s2_valid) begin
      result <= z;
      status <= flags;
    end
  end

endmodule

// ==== src/fpm_regs_pkg.sv ====
// AXI4-Lite response codes and register index type for the multiplier control port
package fpm_regs_pkg;

  // Only the two responses this slave ever returns
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_t;

  // Word index, address bits 4 down to 2
  typedef logic [2:0] reg_idx_t;

endpackage

// ==== src/fpm_format_pkg.sv ====
// Floating-point format types, rounding modes and status flags for the multiplier
`include "fpm_defs.svh"

package fpm_format_pkg;

  // Float word split into its three fields
  typedef struct packed {
    logic                      sign;
    logic [`FPM_EXP_WIDTH-1:0] exp;
    logic [`FPM_SIG_WIDTH-1:0] frac;
  } fp_word_t;

  // Biased exponent sum, two extra bits for overflow and underflow
  typedef logic signed [`FPM_EXP_WIDTH+1:0] exp_sum_t;

  // Full product of the two significands with hidden ones
  typedef logic [2*(`FPM_SIG_WIDTH+1)-1:0] prod_t;

  // Codes 6 and 7 are not listed and round toward zero
  typedef enum logic [2:0] {
    RND_NEAREST_EVEN = 3'd0,
    RND_TO_ZERO      = 3'd1,
    RND_TO_POS       = 3'd2,
    RND_TO_NEG       = 3'd3,
    RND_NEAREST_UP   = 3'd4,
    RND_AWAY         = 3'd5
  } rnd_mode_t;

  // Status flags, top bit first
  typedef struct packed {
    logic inexact;
    logic huge;
    logic tiny;
    logic invalid;
    logic infinity;
    logic zero;
  } fp_status_t;

endpackage

// ==== src/fpm_defs.svh ====
// FP multiplier macros for format widths, exponent bias, register map and pipeline depth
`ifndef FPM_DEFS_SVH
`define FPM_DEFS_SVH

// ----------------------------------------------------------
// Single-precision format
// ----------------------------------------------------------
`define FPM_SIG_WIDTH 23
`define FPM_EXP_WIDTH 8
`define FPM_BIAS 127

// All-ones exponent field, read as infinity
`define FPM_EXP_MAX 255

// ----------------------------------------------------------
// Register byte offsets
// ----------------------------------------------------------
`define FPM_REG_OPA 'h00
`define FPM_REG_OPB 'h04
`define FPM_REG_RND 'h08
`define FPM_REG_RESULT 'h0C
`define FPM_REG_STATUS 'h10

// Registered datapath stages between launch and result
`define FPM_LATENCY 2

`endif
